/* logic/dll_tx_pkg.sv */
/*
  Shared types and constants for the PCIe DLL transmit path.
  The data path is fixed at 32 bits; byte lane 0 (bits 7:0) goes out first.
  Only 3-DW-header TLP kinds are listed; all others need no credit.
*/
package dll_tx_pkg;

  typedef logic [31:0] dword_t;
  typedef logic [3:0]  keep_t;
  typedef logic [11:0] seq_num_t;
  typedef logic [7:0]  hdr_credit_t;
  typedef logic [11:0] data_credit_t;
  typedef logic [9:0]  tlp_len_t;
  typedef logic [31:0] crc_t;

  // credit class of a TLP, picked from its fmt/type byte
  typedef enum logic [2:0] {
    CC_NONE,
    CC_P_HDR,
    CC_P_DATA,
    CC_NP_HDR,
    CC_NP_DATA,
    CC_CPL_HDR,
    CC_CPL_DATA
  } credit_class_e;

  // fmt/type byte values
  localparam logic [7:0] TK_MRD    = 8'h00;
  localparam logic [7:0] TK_MWR    = 8'h40;
  localparam logic [7:0] TK_IORD   = 8'h02;
  localparam logic [7:0] TK_IOWR   = 8'h42;
  localparam logic [7:0] TK_CFGRD0 = 8'h04;
  localparam logic [7:0] TK_CFGWR0 = 8'h44;
  localparam logic [7:0] TK_MSG    = 8'h30;
  localparam logic [7:0] TK_MSGD   = 8'h70;
  localparam logic [7:0] TK_CPL    = 8'h0A;
  localparam logic [7:0] TK_CPLD   = 8'h4A;

  // one data credit covers 16 bytes
  localparam int DW_PER_DATA_CREDIT = 4;

  // reflected form of 04C11DB7
  localparam crc_t CRC_POLY = 32'hEDB88320;

endpackage

/* logic/tlp_stream_if.sv */
/*
  Valid/ready word stream between internal stages.
  A word moves on a clock edge with valid and ready both high.
*/
`timescale 1ns/100ps

interface tlp_stream_if;
  import dll_tx_pkg::*;

  dword_t data;
  keep_t  keep;
  logic   valid;
  logic   last;
  logic   ready;

  modport src (
    output data,
    output keep,
    output valid,
    output last,
    input  ready
  );

  modport dst (
    input  data,
    input  keep,
    input  valid,
    input  last,
    output ready
  );

endinterface

/* logic/stream_skid_buffer.sv */
/*
  Two-entry skid register. Upstream ready comes straight from a flop,
  so it does not depend on downstream ready in the same cycle.
  Adds one cycle of latency and keeps full throughput.
*/
`timescale 1ns/100ps

module stream_skid_buffer
  import dll_tx_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  tlp_stream_if.dst up,
  tlp_stream_if.src dn
);

  dword_t main_data_q, skid_data_q;
  keep_t  main_keep_q, skid_keep_q;
  logic   main_last_q, skid_last_q;
  logic   main_valid_q, skid_valid_q;
  logic   ready_q;
  logic   up_fire;
  logic   dn_free;
  logic   skid_valid_d;

  assign up_fire = up.valid && ready_q;
  // main register can take a word this cycle
  assign dn_free = !main_valid_q || dn.ready;
  assign skid_valid_d = dn_free ? 1'b0 : (skid_valid_q || up_fire);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      if (dn_free) begin
        main_valid_q <= skid_valid_q || up_fire;
      end
      skid_valid_q <= skid_valid_d;
      ready_q      <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dn_free) begin
      // skid entry drains first, upstream is held off while it is full
      if (skid_valid_q) begin
        main_data_q <= skid_data_q;
        main_keep_q <= skid_keep_q;
        main_last_q <= skid_last_q;
      end else if (up_fire) begin
        main_data_q <= up.data;
        main_keep_q <= up.keep;
        main_last_q <= up.last;
      end
    end else if (up_fire) begin
      skid_data_q <= up.data;
      skid_keep_q <= up.keep;
      skid_last_q <= up.last;
    end
  end

  assign up.ready = ready_q;
  assign dn.data  = main_data_q;
  assign dn.keep  = main_keep_q;
  assign dn.last  = main_last_q;
  assign dn.valid = main_valid_q;

endmodule

/* logic/fc_credit_gate.sv */
/*
  Flow-control credit gate for P, NP and CPL header and data credits.
  Limits and counters wrap at their field width; all start at 0, so
  nothing passes before the first update. Grant is combinational.
*/
`timescale 1ns/100ps

module fc_credit_gate
  import dll_tx_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         update_fc_i,
  input  hdr_credit_t  fc_ph_i,
  input  hdr_credit_t  fc_nph_i,
  input  hdr_credit_t  fc_cplh_i,
  input  data_credit_t fc_pd_i,
  input  data_credit_t fc_npd_i,
  input  data_credit_t fc_cpld_i,
  input  dword_t       hdr_dw0_i,
  input  logic         req_i,
  output logic         grant_o
);

  hdr_credit_t   ph_lim_q, nph_lim_q, cplh_lim_q;
  hdr_credit_t   ph_used_q, nph_used_q, cplh_used_q;
  data_credit_t  pd_lim_q, npd_lim_q, cpld_lim_q;
  data_credit_t  pd_used_q, npd_used_q, cpld_used_q;
  credit_class_e cls;
  tlp_len_t      tlp_len;
  data_credit_t  len_credits;
  data_credit_t  data_req;
  logic          need_ph, need_pd, need_nph, need_npd, need_cplh, need_cpld;
  logic          room_ok;

  function automatic logic hdr_room(hdr_credit_t lim, hdr_credit_t used);
    hdr_credit_t avail;
    avail = lim - used;
    return avail != '0;
  endfunction

  function automatic logic data_room(data_credit_t lim, data_credit_t used,
                                     data_credit_t req);
    data_credit_t avail;
    avail = lim - used;
    return avail >= req;
  endfunction

  always_comb begin
    unique case (hdr_dw0_i[7:0])
      TK_MRD, TK_IORD, TK_CFGRD0: cls = CC_NP_HDR;
      TK_IOWR, TK_CFGWR0:         cls = CC_NP_DATA;
      TK_MWR, TK_MSGD:            cls = CC_P_DATA;
      TK_MSG:                     cls = CC_P_HDR;
      TK_CPL:                     cls = CC_CPL_HDR;
      TK_CPLD:                    cls = CC_CPL_DATA;
      default:                    cls = CC_NONE;
    endcase
  end

  // length sits in lane 2 bits 1:0 and lane 3
  assign tlp_len     = {hdr_dw0_i[17:16], hdr_dw0_i[31:24]};
  assign len_credits = data_credit_t'(tlp_len / DW_PER_DATA_CREDIT);
  assign data_req    = (cls == CC_NP_DATA || len_credits == '0) ? data_credit_t'(1)
                                                                : len_credits;

  assign need_ph   = (cls == CC_P_HDR) || (cls == CC_P_DATA);
  assign need_pd   = (cls == CC_P_DATA);
  assign need_nph  = (cls == CC_NP_HDR) || (cls == CC_NP_DATA);
  assign need_npd  = (cls == CC_NP_DATA);
  assign need_cplh = (cls == CC_CPL_HDR) || (cls == CC_CPL_DATA);
  assign need_cpld = (cls == CC_CPL_DATA);

  assign room_ok = (!need_ph   || hdr_room(ph_lim_q, ph_used_q)) &&
                   (!need_nph  || hdr_room(nph_lim_q, nph_used_q)) &&
                   (!need_cplh || hdr_room(cplh_lim_q, cplh_used_q)) &&
                   (!need_pd   || data_room(pd_lim_q, pd_used_q, data_req)) &&
                   (!need_npd  || data_room(npd_lim_q, npd_used_q, data_req)) &&
                   (!need_cpld || data_room(cpld_lim_q, cpld_used_q, data_req));

  assign grant_o = req_i && room_ok;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_lim_q    <= '0;
      nph_lim_q   <= '0;
      cplh_lim_q  <= '0;
      pd_lim_q    <= '0;
      npd_lim_q   <= '0;
      cpld_lim_q  <= '0;
      ph_used_q   <= '0;
      nph_used_q  <= '0;
      cplh_used_q <= '0;
      pd_used_q   <= '0;
      npd_used_q  <= '0;
      cpld_used_q <= '0;
    end else begin
      if (update_fc_i) begin
        ph_lim_q   <= fc_ph_i;
        nph_lim_q  <= fc_nph_i;
        cplh_lim_q <= fc_cplh_i;
        pd_lim_q   <= fc_pd_i;
        npd_lim_q  <= fc_npd_i;
        cpld_lim_q <= fc_cpld_i;
      end
      if (grant_o) begin
        if (need_ph)   ph_used_q   <= ph_used_q + hdr_credit_t'(1);
        if (need_nph)  nph_used_q  <= nph_used_q + hdr_credit_t'(1);
        if (need_cplh) cplh_used_q <= cplh_used_q + hdr_credit_t'(1);
        if (need_pd)   pd_used_q   <= pd_used_q + data_req;
        if (need_npd)  npd_used_q  <= npd_used_q + data_req;
        if (need_cpld) cpld_used_q <= cpld_used_q + data_req;
      end
    end
  end

endmodule

/* logic/lcrc_engine.sv */
/*
  Reflected CRC-32 accumulator, initial value all ones.
  A clear and a fold in the same cycle fold onto a fresh all-ones value.
  lcrc_o is valid the cycle after the last fold.
*/
`timescale 1ns/100ps

module lcrc_engine
  import dll_tx_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   clear_i,
  input  logic   en_i,
  input  dword_t data_i,
  input  keep_t  keep_i,
  output crc_t   lcrc_o
);

  crc_t crc_q;
  crc_t crc_d;

  // one byte through the LSB-first shift register
  function automatic crc_t fold_byte(crc_t crc, logic [7:0] b);
    crc_t c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  always_comb begin
    crc_d = clear_i ? '1 : crc_q;
    if (en_i) begin
      // lane 0 is the first byte on the wire
      for (int lane = 0; lane < 4; lane++) begin
        if (keep_i[lane]) begin
          crc_d = fold_byte(crc_d, data_i[8*lane +: 8]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else begin
      crc_q <= crc_d;
    end
  end

  assign lcrc_o = ~crc_q;

endmodule

/* logic/tlp_framer.sv */
/*
  Puts the sequence number in front of each TLP and the LCRC behind it.
  The two sequence bytes shift the TLP by half a word, so two bytes are
  carried between input words. One TLP at a time; input must be whole dwords.
  The carried tail bytes take one extra cycle to enter the LCRC.
*/
`timescale 1ns/100ps

module tlp_framer
  import dll_tx_pkg::*;
#(
  parameter seq_num_t SEQ_INIT = '0
) (
  input  logic      clk_i,
  input  logic      rst_i,
  tlp_stream_if.dst in_s,
  tlp_stream_if.src out_s,
  output dword_t    hdr_dw0_o,
  output logic      req_o,
  input  logic      grant_i,
  output seq_num_t  seq_num_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_CREDIT,
    ST_STREAM,
    ST_CRC_WORD,
    ST_CRC_TAIL
  } framer_state_e;

  framer_state_e state_q, state_d;
  seq_num_t      seq_q;
  logic [15:0]   carry_q;
  logic          tail_folded_q;
  logic          in_fire;
  logic          out_fire;
  logic          crc_clear;
  logic          crc_en;
  keep_t         crc_keep;
  crc_t          lcrc;

  assign in_fire  = in_s.valid && in_s.ready;
  assign out_fire = out_s.valid && out_s.ready;

  always_comb begin
    state_d     = state_q;
    req_o       = 1'b0;
    in_s.ready  = 1'b0;
    out_s.valid = 1'b0;
    out_s.keep  = 4'b1111;
    out_s.last  = 1'b0;
    out_s.data  = {in_s.data[15:0], carry_q};
    crc_en      = 1'b0;
    crc_keep    = 4'b1111;
    case (state_q)
      ST_IDLE, ST_WAIT_CREDIT: begin
        // the grant is only useful when the head word can leave at once
        req_o       = in_s.valid && out_s.ready;
        out_s.data  = {in_s.data[15:0], seq_q[7:0], 4'h0, seq_q[11:8]};
        out_s.valid = grant_i;
        in_s.ready  = grant_i;
        crc_en      = grant_i;
        if (grant_i) begin
          state_d = in_s.last ? ST_CRC_WORD : ST_STREAM;
        end else if (in_s.valid) begin
          state_d = ST_WAIT_CREDIT;
        end
      end
      ST_STREAM: begin
        out_s.valid = in_s.valid;
        in_s.ready  = out_s.ready;
        crc_en      = out_fire;
        if (out_fire && in_s.last) begin
          state_d = ST_CRC_WORD;
        end
      end
      ST_CRC_WORD: begin
        out_s.data = {lcrc[15:0], carry_q};
        if (!tail_folded_q) begin
          // last two TLP bytes sit in lanes 0 and 1
          crc_en   = 1'b1;
          crc_keep = 4'b0011;
        end else begin
          out_s.valid = 1'b1;
          if (out_fire) begin
            state_d = ST_CRC_TAIL;
          end
        end
      end
      ST_CRC_TAIL: begin
        out_s.data  = {16'h0, lcrc[31:16]};
        out_s.keep  = 4'b0011;
        out_s.last  = 1'b1;
        out_s.valid = 1'b1;
        if (out_fire) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      seq_q         <= SEQ_INIT;
      tail_folded_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      tail_folded_q <= (state_q == ST_CRC_WORD);
      if (state_q == ST_CRC_TAIL && out_fire) begin
        seq_q <= seq_q + seq_num_t'(1);
      end
    end
  end

  // upper half of each input word waits for the next output word
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      carry_q <= in_s.data[31:16];
    end
  end

  // every pass through idle restarts the running CRC
  assign crc_clear = (state_q == ST_IDLE);

  lcrc_engine lcrc_engine_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (crc_clear),
    .en_i    (crc_en),
    .data_i  (out_s.data),
    .keep_i  (crc_keep),
    .lcrc_o  (lcrc)
  );

  assign hdr_dw0_o = in_s.data;
  assign seq_num_o = seq_q;

endmodule

/* logic/dll_tx_top.sv */
/*
  PCIe data link layer transmit path: input skid, framer with credit gate,
  output skid. Input words are whole dwords, so input keep is all ones.
*/
`timescale 1ns/100ps

module dll_tx_top
  import dll_tx_pkg::*;
#(
  parameter seq_num_t SEQ_INIT = '0
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  dword_t       s_tdata_i,
  input  logic         s_tvalid_i,
  input  logic         s_tlast_i,
  output logic         s_tready_o,
  output dword_t       m_tdata_o,
  output keep_t        m_tkeep_o,
  output logic         m_tvalid_o,
  output logic         m_tlast_o,
  input  logic         m_tready_i,
  output seq_num_t     seq_num_o,
  input  logic         update_fc_i,
  input  hdr_credit_t  fc_ph_i,
  input  hdr_credit_t  fc_nph_i,
  input  hdr_credit_t  fc_cplh_i,
  input  data_credit_t fc_pd_i,
  input  data_credit_t fc_npd_i,
  input  data_credit_t fc_cpld_i
);

  tlp_stream_if s_port ();
  tlp_stream_if in_s ();
  tlp_stream_if out_s ();
  tlp_stream_if m_port ();

  dword_t hdr_dw0;
  logic   credit_req;
  logic   credit_grant;

  assign s_port.data  = s_tdata_i;
  assign s_port.keep  = '1;
  assign s_port.valid = s_tvalid_i;
  assign s_port.last  = s_tlast_i;
  assign s_tready_o   = s_port.ready;

  assign m_tdata_o    = m_port.data;
  assign m_tkeep_o    = m_port.keep;
  assign m_tvalid_o   = m_port.valid;
  assign m_tlast_o    = m_port.last;
  assign m_port.ready = m_tready_i;

  stream_skid_buffer in_buf_i (.clk_i(clk_i), .rst_i(rst_i), .up(s_port), .dn(in_s));

  tlp_framer #(.SEQ_INIT(SEQ_INIT)) tlp_framer_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in_s      (in_s),
    .out_s     (out_s),
    .hdr_dw0_o (hdr_dw0),
    .req_o     (credit_req),
    .grant_i   (credit_grant),
    .seq_num_o (seq_num_o)
  );

  fc_credit_gate fc_credit_gate_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .update_fc_i (update_fc_i),
    .fc_ph_i     (fc_ph_i),
    .fc_nph_i    (fc_nph_i),
    .fc_cplh_i   (fc_cplh_i),
    .fc_pd_i     (fc_pd_i),
    .fc_npd_i    (fc_npd_i),
    .fc_cpld_i   (fc_cpld_i),
    .hdr_dw0_i   (hdr_dw0),
    .req_i       (credit_req),
    .grant_o     (credit_grant)
  );

  stream_skid_buffer out_buf_i (.clk_i(clk_i), .rst_i(rst_i), .up(out_s), .dn(m_port));

endmodule

/* tests/dll_tx_assert.sv */
/*
  Output stream checks for the DLL transmit path, bound into the top level.
  Keep rules assume every TLP leaves as whole words plus a 2-byte tail.
*/
`timescale 1ns/100ps

module dll_tx_assert
  import dll_tx_pkg::*;
(
  input logic   clk_i,
  input logic   rst_i,
  input dword_t m_tdata_o,
  input keep_t  m_tkeep_o,
  input logic   m_tvalid_o,
  input logic   m_tlast_o,
  input logic   m_tready_i
);

  // a stalled word must not change
  assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) &&
      $stable(m_tkeep_o) && $stable(m_tlast_o))
    else $error("output word changed while stalled");

  assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_o && !m_tlast_o |-> m_tkeep_o == 4'b1111)
    else $error("partial keep on a non-last word");

  assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_o && m_tlast_o |-> m_tkeep_o == 4'b0011)
    else $error("last word keep is not 0011");

  assert property (@(posedge clk_i) rst_i |=> !m_tvalid_o)
    else $error("output valid during reset");

endmodule

bind dll_tx_top dll_tx_assert dll_tx_assert_i (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .m_tdata_o  (m_tdata_o),
  .m_tkeep_o  (m_tkeep_o),
  .m_tvalid_o (m_tvalid_o),
  .m_tlast_o  (m_tlast_o),
  .m_tready_i (m_tready_i)
);

/* tests/dll_tx_tasks.svh */
/*
  Drive, model, compare and test tasks for the DLL transmit testbench.
  Included inside dll_tx_tb; uses its signals and queues directly.
*/
`ifndef DLL_TX_TASKS_SVH
`define DLL_TX_TASKS_SVH

function automatic logic [31:0] xorshift(logic [31:0] s);
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

function automatic logic [31:0] next_payload();
  payload_state = xorshift(payload_state);
  return payload_state;
endfunction

// reflected CRC-32, one byte at a time
function automatic crc_t crc_byte(crc_t crc, logic [7:0] b);
  crc = crc ^ {24'h0, b};
  for (int i = 0; i < 8; i++) begin
    crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
  end
  return crc;
endfunction

task automatic check_word(string name, dword_t exp, dword_t act);
  if (exp !== act) begin
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_keep(string name, keep_t exp, keep_t act);
  if (exp !== act) begin
    $display("ERROR %s: expected %b, actual %b", name, exp, act);
    errors++;
  end
endtask

task automatic check_seq(string name, seq_num_t exp, seq_num_t act);
  if (exp !== act) begin
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_flag(string name, logic exp, logic act);
  if (exp !== act) begin
    $display("ERROR %s: expected %b, actual %b", name, exp, act);
    errors++;
  end
endtask

// fmt/type in lane 0, length in lane 2 bits 1:0 and lane 3
task automatic build_tlp(logic [7:0] kind, tlp_len_t len, int nwords);
  tx_q.delete();
  tx_q.push_back({len[7:0], 6'h0, len[9:8], 8'h00, kind});
  for (int i = 1; i < nwords; i++) begin
    tx_q.push_back(next_payload());
  end
endtask

task automatic send_tlp();
  for (int i = 0; i < tx_q.size(); i++) begin
    s_tdata_i  <= tx_q[i];
    s_tvalid_i <= 1'b1;
    s_tlast_i  <= (i == tx_q.size() - 1);
    do @(posedge clk_i); while (!s_tready_o);
  end
  s_tvalid_i <= 1'b0;
  s_tlast_i  <= 1'b0;
endtask

// expected words: sequence bytes, TLP bytes, LCRC low byte first
task automatic model_tlp();
  logic [7:0] b[$];
  crc_t       crc;
  b.push_back({4'h0, exp_seq[11:8]});
  b.push_back(exp_seq[7:0]);
  foreach (tx_q[i]) begin
    for (int k = 0; k < 4; k++) b.push_back(tx_q[i][8*k +: 8]);
  end
  crc = '1;
  foreach (b[i]) crc = crc_byte(crc, b[i]);
  crc = ~crc;
  for (int k = 0; k < 4; k++) b.push_back(crc[8*k +: 8]);
  b.push_back(8'h00);
  b.push_back(8'h00);
  for (int i = 0; i < b.size(); i += 4) begin
    exp_data.push_back({b[i+3], b[i+2], b[i+1], b[i]});
    exp_keep.push_back(i + 4 == b.size() ? 4'b0011 : 4'b1111);
    exp_last.push_back(i + 4 == b.size());
  end
  exp_seq    = exp_seq + seq_num_t'(1);
  words_sent += tx_q.size() + 2;
endtask

task automatic compare_output(string name);
  while (got_data.size() < exp_data.size()) @(posedge clk_i);
  if (got_data.size() != exp_data.size()) begin
    $display("%s: more output words than expected", name);
    errors++;
  end
  foreach (exp_data[i]) begin
    check_word(name, exp_data[i], got_data[i]);
    check_keep(name, exp_keep[i], got_keep[i]);
    check_flag(name, exp_last[i], got_last[i]);
  end
  exp_data.delete();
  exp_keep.delete();
  exp_last.delete();
  got_data.delete();
  got_keep.delete();
  got_last.delete();
  check_seq(name, exp_seq, seq_num_o);
endtask

task automatic set_credits(int ph, int nph, int cplh, int pd, int npd, int cpld);
  fc_ph_i     <= hdr_credit_t'(ph);
  fc_nph_i    <= hdr_credit_t'(nph);
  fc_cplh_i   <= hdr_credit_t'(cplh);
  fc_pd_i     <= data_credit_t'(pd);
  fc_npd_i    <= data_credit_t'(npd);
  fc_cpld_i   <= data_credit_t'(cpld);
  update_fc_i <= 1'b1;
  @(posedge clk_i);
  update_fc_i <= 1'b0;
endtask

// output must stay idle while a TLP waits for credit
task automatic expect_idle(string name, int cycles);
  repeat (cycles) begin
    @(posedge clk_i);
    check_flag(name, 1'b0, m_tvalid_o);
  end
endtask

task automatic end_test(string name, int err_before);
  tests_run++;
  $display("%s: %s", name, (errors == err_before) ? "ok" : "failed");
endtask

`endif

/* tests/dll_tx_tb.sv */
/*
  Directed tests for the DLL transmit path. SEQ_INIT sits near 4095 so
  the sequence number wraps during the run. Random data uses xorshift.
*/
`timescale 1ns/100ps

module dll_tx_tb
  import dll_tx_pkg::*;
;

  localparam seq_num_t SEQ_INIT = 12'hFFD;

  logic         clk_i;
  logic         rst_i;
  dword_t       s_tdata_i;
  logic         s_tvalid_i, s_tlast_i, s_tready_o;
  dword_t       m_tdata_o;
  keep_t        m_tkeep_o;
  logic         m_tvalid_o, m_tlast_o, m_tready_i;
  seq_num_t     seq_num_o;
  logic         update_fc_i;
  hdr_credit_t  fc_ph_i, fc_nph_i, fc_cplh_i;
  data_credit_t fc_pd_i, fc_npd_i, fc_cpld_i;

  dword_t      tx_q[$];
  dword_t      exp_data[$], got_data[$];
  keep_t       exp_keep[$], got_keep[$];
  logic        exp_last[$], got_last[$];
  seq_num_t    exp_seq = SEQ_INIT;
  logic [31:0] payload_state = 32'd25487;
  logic [31:0] stall_state = 32'd25487 ^ 32'h5A5A5A5A;
  logic        stall_en = 1'b0;
  int          errors = 0;
  int          tests_run = 0;
  int          words_sent = 0;
  int          cycles = 0;

  dll_tx_top #(.SEQ_INIT(SEQ_INIT)) dll_tx_top_i (.*);

  `include "dll_tx_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (!rst_i && m_tvalid_o && m_tready_i) begin
      got_data.push_back(m_tdata_o);
      got_keep.push_back(m_tkeep_o);
      got_last.push_back(m_tlast_o);
    end
  end

  // ready stalls on roughly one cycle in four
  always @(posedge clk_i) begin
    if (stall_en) begin
      stall_state <= xorshift(stall_state);
      m_tready_i  <= (stall_state[1:0] != 2'b00);
    end else begin
      m_tready_i <= 1'b1;
    end
  end

  // budget of 40 cycles per word, plus a fixed margin for the credit holds
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 40 * words_sent + 2000) begin
      $display("timeout: output did not arrive within the cycle limit");
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic test_reset_hold();
    int e;
    e = errors;
    check_seq("reset_hold seq", SEQ_INIT, seq_num_o);
    check_flag("reset_hold valid", 1'b0, m_tvalid_o);
    check_flag("reset_hold ready low", 1'b0, s_tready_o);
    @(posedge clk_i);
    check_flag("reset_hold ready high", 1'b1, s_tready_o);
    build_tlp(TK_MWR, 1, 4);
    model_tlp();
    fork
      send_tlp();
    join_none
    expect_idle("reset_hold no credit", 30);
    // two words fill the input buffer and hold off the rest
    check_flag("reset_hold ready held", 1'b0, s_tready_o);
    set_credits(100, 100, 100, 1000, 100, 1000);
    compare_output("reset_hold");
    end_test("reset_hold", e);
  endtask

  task automatic test_framing();
    int e;
    e = errors;
    build_tlp(TK_MWR, 1, 1);
    model_tlp();
    send_tlp();
    compare_output("framing 1dw");
    build_tlp(TK_MWR, 4, 4);
    model_tlp();
    send_tlp();
    compare_output("framing 4dw");
    build_tlp(TK_MWR, 9, 9);
    model_tlp();
    send_tlp();
    compare_output("framing 9dw");
    end_test("framing", e);
  endtask

  // 4 posted headers used so far, limit 5 leaves room for one
  task automatic test_hdr_credit();
    int e;
    e = errors;
    set_credits(5, 100, 100, 1000, 100, 1000);
    build_tlp(TK_MWR, 1, 4);
    model_tlp();
    send_tlp();
    compare_output("hdr_credit first");
    build_tlp(TK_MWR, 1, 4);
    model_tlp();
    fork
      send_tlp();
    join_none
    expect_idle("hdr_credit held", 30);
    set_credits(6, 100, 100, 1000, 100, 1000);
    compare_output("hdr_credit released");
    end_test("hdr_credit", e);
  endtask

  // 7 posted data credits used; limit 8 is one short of the 2 needed
  task automatic test_data_credit();
    int e;
    e = errors;
    set_credits(100, 100, 100, 8, 100, 1000);
    build_tlp(TK_MWR, 8, 11);
    model_tlp();
    fork
      send_tlp();
    join_none
    expect_idle("data_credit held", 30);
    // posted credits run out with this TLP, so the next two need their own
    set_credits(7, 100, 100, 9, 100, 1000);
    compare_output("data_credit released");
    build_tlp(TK_CPLD, 4, 7);
    model_tlp();
    send_tlp();
    compare_output("data_credit cpld");
    build_tlp(TK_MRD, 1, 3);
    model_tlp();
    send_tlp();
    compare_output("data_credit mrd");
    end_test("data_credit", e);
  endtask

  task automatic test_seq_stall();
    logic [7:0] kinds[7];
    logic [31:0] r;
    tlp_len_t len;
    int e;
    e = errors;
    kinds = '{TK_MRD, TK_MWR, TK_MSG, TK_MSGD, TK_CPL, TK_CPLD, TK_IOWR};
    set_credits(250, 250, 250, 4000, 4000, 4000);
    stall_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      r = next_payload();
      len = tlp_len_t'(1 + (r[15:8] % 12));
      build_tlp(kinds[r[31:16] % 7], len, kinds[r[31:16] % 7][6] ? 3 + len : 3);
      model_tlp();
      send_tlp();
      compare_output($sformatf("seq_stall tlp %0d", i));
    end
    stall_en = 1'b0;
    end_test("seq_stall", e);
  endtask

  initial begin
    rst_i       = 1'b1;
    s_tdata_i   = '0;
    s_tvalid_i  = 1'b0;
    s_tlast_i   = 1'b0;
    m_tready_i  = 1'b1;
    update_fc_i = 1'b0;
    fc_ph_i     = '0;
    fc_nph_i    = '0;
    fc_cplh_i   = '0;
    fc_pd_i     = '0;
    fc_npd_i    = '0;
    fc_cpld_i   = '0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    test_reset_hold();
    test_framing();
    test_hdr_credit();
    test_data_credit();
    test_seq_stall();
    repeat (5) @(posedge clk_i);
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+tests
logic/dll_tx_pkg.sv
logic/tlp_stream_if.sv
logic/stream_skid_buffer.sv
logic/fc_credit_gate.sv
logic/lcrc_engine.sv
logic/tlp_framer.sv
logic/dll_tx_top.sv
tests/dll_tx_assert.sv
tests/dll_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the DLL transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module dll_tx_tb -o dll_tx_sim || exit 1
out="$(./obj_dir/dll_tx_sim)"
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
